//--- mini_core.f
+incdir+verilog
verilog/mini_core_pkg.sv
verilog/reg_file.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/mini_core_top.sv
tb/mini_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mini_core_tb \
    -f mini_core.f -o mini_core_sim \
    && ./obj_dir/mini_core_sim > sim.log 2>&1 \
    || echo "build or run error"
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- tb/mini_core_tb.sv
`include "mini_core_macros.svh"
`timescale 1ns/1ps

module mini_core_tb import mini_core_pkg::*; ();

    localparam int PROG_LEN    = 40;
    localparam int TIMEOUT     = PROG_LEN * 6 + 100;
    localparam int SEC_NUM     = 4;
    localparam int EXP_RETIRES = 30; // program path with skipped words removed

    logic    clk = 1'b0;
    logic    arst_n;
    logic    imem_req;
    word_t   imem_addr;
    logic    imem_busy;
    word_t   imem_data;
    logic    imem_valid;
    retire_t debug_wb;

    word_t      rom [64];
    integer     seed = 32'hb2f7_cd5a;
    logic       mem_pend = 1'b0;
    logic [1:0] mem_cnt = '0;
    word_t      mem_addr = '0;

    word_t       model_pc;
    word_t       model_regs [32];
    word_t       exp_next;
    logic        exp_we;
    reg_idx_t    exp_idx;
    word_t       exp_data;
    logic [63:0] pc_seen;
    int          retire_cnt;

    int   cycle_cnt = 0;
    int   err_cnt = 0;
    int   err_mark = 0;
    int   pass_tests = 0;
    int   fail_tests = 0;
    int   busy_cnt = 0;
    int   slow_cnt = 0;
    int   sec = 0;
    logic sec_done = 1'b0;
    logic first_req_done = 1'b0;
    logic reset_reported = 1'b0;

    mini_core_top mini_core_top_i (
        .clk, .arst_n,
        .imem_req,
        .imem_addr,
        .imem_busy,
        .imem_data,
        .imem_valid,
        .debug_wb
    );

    always #50 clk = ~clk;

    function automatic word_t r_format(input logic [10:0] fn, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk);
        return {`MC_OP_RTYPE, rd, rj, rk, fn};
    endfunction

    function automatic word_t i_format(input logic [5:0] op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [15:0] imm);
        return {op, rd, rj, imm};
    endfunction

    function automatic word_t section_end(input int s);
        case (s)
            0:       return 32'd24;
            1:       return 32'd44;
            2:       return 32'd72;
            3:       return 32'd136;
            default: return '1;
        endcase
    endfunction

    function automatic string section_name(input int s);
        case (s)
            0:       return "alu_rtype";
            1:       return "immediate";
            2:       return "dependency";
            default: return "branch";
        endcase
    endfunction

    task automatic load_program;
        for (int i = 0; i < 64; i++) begin
            rom[i] = i_format(`MC_OP_ORI, 5'd0, 5'd0, 16'(i * 4)); // filler keyed by address
        end
        rom[0]  = i_format(`MC_OP_ADDI, 5'd1, 5'd0, 16'h1234);
        rom[1]  = i_format(`MC_OP_ADDI, 5'd2, 5'd0, 16'h0f0f);
        rom[2]  = r_format(`MC_FN_ADD, 5'd3, 5'd1, 5'd2);
        rom[3]  = r_format(`MC_FN_SUB, 5'd4, 5'd1, 5'd2);
        rom[4]  = r_format(`MC_FN_AND, 5'd5, 5'd1, 5'd2);
        rom[5]  = r_format(`MC_FN_OR, 5'd6, 5'd1, 5'd2);
        rom[6]  = r_format(`MC_FN_XOR, 5'd7, 5'd1, 5'd2);
        rom[7]  = i_format(`MC_OP_ADDI, 5'd8, 5'd0, 16'hfffb); // -5
        rom[8]  = i_format(`MC_OP_ORI, 5'd9, 5'd0, 16'h8001);
        rom[9]  = i_format(`MC_OP_ADDI, 5'd0, 5'd1, 16'h0007); // write to r0
        rom[10] = r_format(`MC_FN_ADD, 5'd10, 5'd0, 5'd1);
        rom[11] = i_format(`MC_OP_ORI, 5'd11, 5'd8, 16'h00f0);
        // chain, each one reads the result before it
        rom[12] = i_format(`MC_OP_ADDI, 5'd12, 5'd0, 16'h0001);
        rom[13] = r_format(`MC_FN_ADD, 5'd12, 5'd12, 5'd12);
        rom[14] = r_format(`MC_FN_ADD, 5'd12, 5'd12, 5'd12);
        rom[15] = r_format(`MC_FN_SUB, 5'd13, 5'd12, 5'd1);
        rom[16] = r_format(`MC_FN_XOR, 5'd14, 5'd13, 5'd12);
        rom[17] = r_format(`MC_FN_OR, 5'd15, 5'd14, 5'd13);
        rom[18] = i_format(`MC_OP_ADDI, 5'd15, 5'd15, 16'hffff);
        rom[19] = i_format(`MC_OP_ADDI, 5'd16, 5'd0, 16'h0003);
        rom[20] = i_format(`MC_OP_ADDI, 5'd17, 5'd0, 16'h0003);
        rom[21] = i_format(`MC_OP_BEQ, 5'd16, 5'd17, 16'd1);  // taken
        rom[22] = i_format(`MC_OP_ADDI, 5'd18, 5'd0, 16'h07ff);
        rom[23] = i_format(`MC_OP_BNE, 5'd16, 5'd17, 16'd2);  // not taken
        rom[24] = i_format(`MC_OP_ADDI, 5'd19, 5'd0, 16'h0009);
        rom[25] = i_format(`MC_OP_BNE, 5'd16, 5'd19, 16'd1);  // taken
        rom[26] = i_format(`MC_OP_ADDI, 5'd18, 5'd0, 16'h07fe);
        rom[27] = i_format(`MC_OP_BEQ, 5'd16, 5'd19, 16'd3);  // not taken
        rom[28] = i_format(`MC_OP_B, 5'd0, 5'd0, 16'd2);
        rom[29] = i_format(`MC_OP_ADDI, 5'd18, 5'd0, 16'h0001);
        rom[30] = i_format(`MC_OP_ADDI, 5'd18, 5'd0, 16'h0002);
        rom[31] = r_format(`MC_FN_ADD, 5'd20, 5'd16, 5'd19);
        rom[32] = i_format(`MC_OP_BEQ, 5'd20, 5'd20, 16'd1);
        rom[33] = i_format(`MC_OP_ADDI, 5'd18, 5'd0, 16'h0003);
        rom[34] = r_format(`MC_FN_OR, 5'd21, 5'd20, 5'd18);  // r18 stays 0 unless a skip leaked
    endtask

    task automatic report_mismatch(input string name, input word_t exp, input word_t got);
        $display("error %0t %s expected %h got %h", $time, name, exp, got);
        err_cnt++;
    endtask

    task automatic report_test(input string name);
        if (err_cnt == err_mark) begin
            pass_tests++;
            $display("test %s passed", name);
        end else begin
            fail_tests++;
            $display("test %s failed with %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    task automatic finish_run;
        $display("tests passed %0d failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        arst_n     = 1'b0;
        imem_busy  = 1'b0;
        imem_valid = 1'b0;
        imem_data  = '0;
        load_program();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    end

    // instruction memory, one request at a time, 1 to 4 cycles to answer
    always @(posedge clk) begin
        logic [31:0] rnd;
        rnd = $random(seed);
        imem_busy  <= (rnd[5:3] == 3'd0);
        imem_valid <= 1'b0;
        if (imem_busy && arst_n) begin
            busy_cnt++;
        end
        if (mem_pend) begin
            if (mem_cnt == 2'd0) begin
                imem_valid <= 1'b1;
                imem_data  <= rom[mem_addr[7:2]];
                mem_pend   <= 1'b0;
            end else begin
                mem_cnt <= mem_cnt - 2'd1;
            end
        end else if (imem_req) begin
            mem_pend <= 1'b1;
            mem_addr <= imem_addr;
            mem_cnt  <= rnd[1:0];
            if (rnd[1:0] != 2'd0) begin
                slow_cnt++;
            end
        end
    end

    // reference model, next instruction from its own pc
    always_comb begin
        word_t w;
        word_t rd_val;
        word_t rj_val;
        word_t rk_val;
        word_t simm;
        w        = rom[model_pc[7:2]];
        rd_val   = model_regs[w[25:21]];
        rj_val   = model_regs[w[20:16]];
        rk_val   = model_regs[w[15:11]];
        simm     = {{16{w[15]}}, w[15:0]};
        exp_we   = 1'b1;
        exp_idx  = w[25:21];
        exp_data = '0;
        exp_next = model_pc + 32'd4;
        case (w[31:26])
            `MC_OP_RTYPE: begin
                case (w[10:0])
                    `MC_FN_ADD: exp_data = rj_val + rk_val;
                    `MC_FN_SUB: exp_data = rj_val - rk_val;
                    `MC_FN_AND: exp_data = rj_val & rk_val;
                    `MC_FN_OR:  exp_data = rj_val | rk_val;
                    `MC_FN_XOR: exp_data = rj_val ^ rk_val;
                    default:    exp_we = 1'b0;
                endcase
            end
            `MC_OP_ADDI: exp_data = rj_val + simm;
            `MC_OP_ORI:  exp_data = rj_val | {16'h0000, w[15:0]};
            `MC_OP_BEQ: begin
                exp_we = 1'b0;
                if (rd_val == rj_val) begin
                    exp_next = model_pc + 32'd4 + (simm << 2);
                end
            end
            `MC_OP_BNE: begin
                exp_we = 1'b0;
                if (rd_val != rj_val) begin
                    exp_next = model_pc + 32'd4 + (simm << 2);
                end
            end
            `MC_OP_B: begin
                exp_we   = 1'b0;
                exp_next = model_pc + 32'd4 + (simm << 2);
            end
            default: exp_we = 1'b0;
        endcase
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model_pc   <= `MC_RESET_PC;
            retire_cnt <= 0;
            pc_seen    <= '0;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] <= '0;
            end
        end else if (debug_wb.valid) begin
            model_pc   <= exp_next;
            retire_cnt <= retire_cnt + 1;
            pc_seen[debug_wb.pc[7:2]] <= 1'b1;
            if (exp_we && exp_idx != '0) begin
                model_regs[exp_idx] <= exp_data;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !debug_wb.valid && !imem_req)
        else begin
            $display("retire or fetch request seen during reset at %0t", $time);
            err_cnt++;
        end

    a_first_addr: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req && !first_req_done |-> imem_addr == `MC_RESET_PC)
        else report_mismatch("imem_addr", `MC_RESET_PC, $sampled(imem_addr));

    a_wb_pc: assert property (@(posedge clk) disable iff (!arst_n)
        debug_wb.valid |-> debug_wb.pc == model_pc)
        else report_mismatch("debug_wb.pc", $sampled(model_pc), $sampled(debug_wb.pc));

    a_wb_we: assert property (@(posedge clk) disable iff (!arst_n)
        debug_wb.valid |-> debug_wb.we == exp_we)
        else report_mismatch("debug_wb.we", 32'($sampled(exp_we)), 32'($sampled(debug_wb.we)));

    a_wb_idx: assert property (@(posedge clk) disable iff (!arst_n)
        debug_wb.valid && exp_we |-> debug_wb.idx == exp_idx)
        else report_mismatch("debug_wb.idx", 32'($sampled(exp_idx)),
                             32'($sampled(debug_wb.idx)));

    a_wb_data: assert property (@(posedge clk) disable iff (!arst_n)
        debug_wb.valid && exp_we |-> debug_wb.data == exp_data)
        else report_mismatch("debug_wb.data", $sampled(exp_data), $sampled(debug_wb.data));

    a_no_repeat: assert property (@(posedge clk) disable iff (!arst_n)
        debug_wb.valid |-> !pc_seen[debug_wb.pc[7:2]])
        else begin
            $display("pc %h retired a second time at %0t", $sampled(debug_wb.pc), $time);
            err_cnt++;
        end

    // reports trail their event by one edge so its assertions are counted
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        sec_done  <= debug_wb.valid && model_pc == section_end(sec);
        if (arst_n && imem_req) begin
            first_req_done <= 1'b1;
        end
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout after %0d cycles with %0d instructions retired",
                     cycle_cnt, retire_cnt);
            $display("Simulation failed");
            $finish;
        end else if (first_req_done && !reset_reported) begin
            report_test("reset_state");
            reset_reported <= 1'b1;
        end else if (sec_done) begin
            report_test(section_name(sec));
            sec <= sec + 1;
            if (sec == SEC_NUM - 1) begin
                a_retire_count: assert (retire_cnt == EXP_RETIRES)
                    else begin
                        $display("error %0t retire_cnt expected %0d got %0d",
                                 $time, EXP_RETIRES, retire_cnt);
                        err_cnt++;
                    end
                a_stalls_seen: assert (busy_cnt > 0 && slow_cnt > 0)
                    else begin
                        $display("memory model never raised busy or never delayed a response");
                        err_cnt++;
                    end
                report_test("latency_busy");
                finish_run();
            end
        end
    end

endmodule

//--- verilog/mini_core_top.sv
`timescale 1ns/1ps

module mini_core_top import mini_core_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    output logic    imem_req,
    output word_t   imem_addr,
    input  logic    imem_busy,
    input  word_t   imem_data,
    input  logic    imem_valid,
    output retire_t debug_wb
);

    fetch_decode_pass_t   pass_if;
    decode_execute_pass_t pass_id;
    fwd_t                 fwd;
    redirect_t            redirect;

    reg_idx_t rj;
    reg_idx_t rk;
    word_t    rj_data;
    word_t    rk_data;
    logic     reg_we;
    reg_idx_t reg_idx;
    word_t    reg_data;

    fetch u_fetch (
        .clk, .arst_n,
        .imem_req,
        .imem_addr,
        .imem_busy,
        .imem_data,
        .imem_valid,
        .redirect,
        .pass_out (pass_if)
    );

    reg_file u_reg_file (
        .clk, .arst_n,
        .rj,
        .rk,
        .rj_data,
        .rk_data,
        .we      (reg_we),
        .rd      (reg_idx),
        .rd_data (reg_data)
    );

    decode u_decode (
        .clk, .arst_n,
        .pass_in  (pass_if),
        .rj,
        .rk,
        .rj_data,
        .rk_data,
        .fwd,
        .redirect,
        .pass_out (pass_id)
    );

    execute u_execute (
        .clk, .arst_n,
        .pass_in  (pass_id),
        .fwd,
        .redirect,
        .reg_we,
        .reg_idx,
        .reg_data,
        .retire   (debug_wb)
    );

endmodule

//--- verilog/execute.sv
`timescale 1ns/1ps

module execute import mini_core_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  decode_execute_pass_t pass_in,
    output fwd_t                 fwd,
    output redirect_t            redirect,
    output logic                 reg_we,
    output reg_idx_t             reg_idx,
    output word_t                reg_data,
    output retire_t              retire
);

    word_t   a;
    word_t   b;
    word_t   result;
    logic    taken;
    retire_t retire_d;

    assign a = pass_in.src_a;
    assign b = pass_in.src_b;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (pass_in.alu_op)
            op_add: result = a + b;
            op_sub: result = a - b;
            op_and: result = a & b;
            op_or:  result = a | b;
            op_xor: result = a ^ b;
            op_beq: taken = (a == b);
            op_bne: taken = (a != b);
            op_b:   taken = 1'b1;
            default: result = '0; // illegal, retires without a write
        endcase
    end

    assign redirect.valid  = pass_in.valid && taken;
    assign redirect.target = pass_in.pc + 4 + (pass_in.br_offset << 2);

    assign retire_d.valid = pass_in.valid;
    assign retire_d.pc    = pass_in.pc;
    assign retire_d.we    = pass_in.valid && pass_in.reg_we;
    assign retire_d.idx   = pass_in.rd;
    assign retire_d.data  = result;

    // write port and forward path see the record before it is registered
    assign reg_we   = retire_d.we;
    assign reg_idx  = retire_d.idx;
    assign reg_data = retire_d.data;
    assign fwd.we   = retire_d.we;
    assign fwd.idx  = retire_d.idx;
    assign fwd.data = retire_d.data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire <= '0;
        end else begin
            retire <= retire_d;
        end
    end

    // a taken branch also empties the slot behind it
    a_redirect_src: assert property (@(posedge clk) disable iff (!arst_n)
        redirect.valid |->
            (pass_in.valid && pass_in.alu_op inside {op_beq, op_bne, op_b}) ##1 !pass_in.valid);

endmodule

//--- verilog/decode.sv
`include "mini_core_macros.svh"
`timescale 1ns/1ps

module decode import mini_core_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  fetch_decode_pass_t   pass_in,
    output reg_idx_t             rj,
    output reg_idx_t             rk,
    input  word_t                rj_data,
    input  word_t                rk_data,
    input  fwd_t                 fwd,
    input  redirect_t            redirect,
    output decode_execute_pass_t pass_out
);

    inst_t                inst;
    alu_op_e              alu_op;
    reg_idx_t             rd;
    logic                 reg_we;
    logic                 use_imm;
    word_t                imm_ext;
    word_t                rj_val;
    word_t                rk_val;
    decode_execute_pass_t pass_d;

    assign inst = pass_in.inst;

    always_comb begin
        alu_op  = op_nop;
        rd      = inst.r.rd;
        rj      = inst.r.rj;
        rk      = inst.r.rk;
        reg_we  = 1'b0;
        use_imm = 1'b0;
        imm_ext = {{(`MC_XLEN-`MC_IMM_W){inst.i.imm[`MC_IMM_W-1]}}, inst.i.imm};
        case (inst.r.opcode)
            `MC_OP_RTYPE: begin
                reg_we = 1'b1;
                case (inst.r.funct)
                    `MC_FN_ADD: alu_op = op_add;
                    `MC_FN_SUB: alu_op = op_sub;
                    `MC_FN_AND: alu_op = op_and;
                    `MC_FN_OR:  alu_op = op_or;
                    `MC_FN_XOR: alu_op = op_xor;
                    default:    reg_we = 1'b0;
                endcase
            end
            `MC_OP_ADDI, `MC_OP_ORI: begin
                rd      = inst.i.rd;
                rj      = inst.i.rj;
                reg_we  = 1'b1;
                use_imm = 1'b1;
                if (inst.i.opcode == `MC_OP_ORI) begin
                    alu_op  = op_or;
                    imm_ext = {{(`MC_XLEN-`MC_IMM_W){1'b0}}, inst.i.imm}; // ori zero extends
                end else begin
                    alu_op = op_add;
                end
            end
            `MC_OP_BEQ, `MC_OP_BNE: begin
                rj     = inst.i.rj;
                rk     = inst.i.rd; // compare rd against rj
                alu_op = (inst.i.opcode == `MC_OP_BEQ) ? op_beq : op_bne;
            end
            `MC_OP_B:  alu_op = op_b;
        endcase
    end

    // execute result lands in the regfile at the next edge, take it now
    assign rj_val = (fwd.we && fwd.idx == rj && rj != '0) ? fwd.data : rj_data;
    assign rk_val = (fwd.we && fwd.idx == rk && rk != '0) ? fwd.data : rk_data;

    assign pass_d.valid     = pass_in.valid;
    assign pass_d.pc        = pass_in.pc;
    assign pass_d.alu_op    = alu_op;
    assign pass_d.rd        = rd;
    assign pass_d.reg_we    = reg_we;
    assign pass_d.src_a     = rj_val;
    assign pass_d.src_b     = use_imm ? imm_ext : rk_val;
    assign pass_d.br_offset = imm_ext;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pass_out <= '0;
        end else if (redirect.valid) begin
            pass_out <= '0; // squash the wrong-path slot
        end else begin
            pass_out <= pass_d;
        end
    end

    // every opcode and funct of the isa
    a_legal_not_nop: assert property (@(posedge clk) disable iff (!arst_n)
        pass_in.valid && !redirect.valid &&
            (inst.r.opcode inside {`MC_OP_ADDI, `MC_OP_ORI, `MC_OP_BEQ, `MC_OP_BNE, `MC_OP_B} ||
             (inst.r.opcode == `MC_OP_RTYPE &&
              inst.r.funct inside {`MC_FN_ADD, `MC_FN_SUB, `MC_FN_AND, `MC_FN_OR, `MC_FN_XOR}))
        |=> pass_out.valid && pass_out.alu_op != op_nop);

endmodule

//--- verilog/fetch.sv
`include "mini_core_macros.svh"
`timescale 1ns/1ps

module fetch import mini_core_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    output logic               imem_req,
    output word_t              imem_addr,
    input  logic               imem_busy,
    input  word_t              imem_data,
    input  logic               imem_valid,
    input  redirect_t          redirect,
    output fetch_decode_pass_t pass_out
);

    word_t pc;      // address of the outstanding or next request
    logic  run;
    logic  pending;
    logic  drop;    // outstanding word belongs to a squashed path

    assign imem_req  = run && !pending && !imem_busy && !redirect.valid;
    assign imem_addr = pc;

    assign pass_out.valid = imem_valid && pending && !drop && !redirect.valid;
    assign pass_out.pc    = pc;
    assign pass_out.inst  = inst_t'(imem_data);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run     <= 1'b0;
            pending <= 1'b0;
            drop    <= 1'b0;
            pc      <= `MC_RESET_PC;
        end else begin
            run <= 1'b1;
            if (imem_req) begin
                pending <= 1'b1;
            end else if (imem_valid) begin
                pending <= 1'b0;
            end

            if (redirect.valid) begin
                pc   <= redirect.target;
                drop <= pending && !imem_valid; // word still on its way
            end else if (imem_valid) begin
                drop <= 1'b0;
                if (!drop) begin
                    pc <= pc + `MC_XLEN'(4);
                end
            end
        end
    end

    // one outstanding request at a time
    a_single_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req |=> !imem_req until imem_valid);

    a_no_stray_valid: assert property (@(posedge clk) disable iff (!arst_n)
        imem_valid |-> pending);

endmodule

//--- verilog/reg_file.sv
`include "mini_core_macros.svh"
`timescale 1ns/1ps

module reg_file import mini_core_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rj,
    input  reg_idx_t rk,
    output word_t    rj_data,
    output word_t    rk_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    rd_data
);

    word_t regs [1:`MC_REG_NUM-1]; // no storage for r0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `MC_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rj_data = (rj == '0) ? '0 : regs[rj];
    assign rk_data = (rk == '0) ? '0 : regs[rk];

    a_wr_idx_known: assert property (@(posedge clk) disable iff (!arst_n)
        we |-> !$isunknown(rd));

endmodule

//--- verilog/mini_core_pkg.sv
`include "mini_core_macros.svh"

package mini_core_pkg;

    typedef logic [`MC_XLEN-1:0] word_t;
    typedef logic [$clog2(`MC_REG_NUM)-1:0] reg_idx_t;

    typedef struct packed {
        logic [`MC_OPCODE_W-1:0] opcode;
        reg_idx_t                rd;
        reg_idx_t                rj;
        reg_idx_t                rk;
        logic [`MC_FUNCT_W-1:0]  funct;
    } r_fmt_t;

    typedef struct packed {
        logic [`MC_OPCODE_W-1:0] opcode;
        reg_idx_t                rd;
        reg_idx_t                rj;
        logic [`MC_IMM_W-1:0]    imm;
    } i_fmt_t;

    // same word, two field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_t;

    typedef enum logic [3:0] {
        op_nop, op_add, op_sub, op_and, op_or, op_xor, op_beq, op_bne, op_b
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        inst_t inst;
    } fetch_decode_pass_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     reg_we;
        word_t    src_a;
        word_t    src_b;
        word_t    br_offset; // in words, sign extended
    } decode_execute_pass_t;

    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        word_t    data;
    } fwd_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     we;
        reg_idx_t idx;
        word_t    data;
    } retire_t;

endpackage

//--- verilog/mini_core_macros.svh
`ifndef MINI_CORE_MACROS_SVH
`define MINI_CORE_MACROS_SVH

`define MC_XLEN      32
`define MC_REG_NUM   32
`define MC_RESET_PC  32'h0000_0000

`define MC_OPCODE_W  6
`define MC_FUNCT_W   11
`define MC_IMM_W     16

// major opcodes, bits 31:26
`define MC_OP_RTYPE  6'h00
`define MC_OP_ADDI   6'h0a
`define MC_OP_ORI    6'h0e
`define MC_OP_B      6'h14
`define MC_OP_BEQ    6'h16
`define MC_OP_BNE    6'h17

// r-type function field, bits 10:0
`define MC_FN_ADD    11'h020
`define MC_FN_SUB    11'h022
`define MC_FN_AND    11'h024
`define MC_FN_OR     11'h025
`define MC_FN_XOR    11'h026

`endif
